// ==== vlog.f ====
stepper_pkg.sv
spi_word.sv
spi_cmd_decoder.sv
move_queue.sv
dda_timer.sv
stepper_spi_top.sv
tb_stepper_spi.sv

// ==== tb_stepper_spi.sv ====
`default_nettype none

module tb_stepper_spi;

  localparam int MOVE_DEPTH_BITS = 2;
  localparam int DEPTH = 1 << MOVE_DEPTH_BITS;

  logic        CLK;
  logic        resetn;
  logic        sck;
  logic        cs;
  logic        copi;
  logic        cipo;
  logic [63:0] encoder_count;
  logic        step;
  logic        dir;
  logic        enable;
  logic        busy;
  logic        buffer_ready;
  stepper_pkg::motor_cfg_t motor_cfg;

  // Check and test bookkeeping
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    err_at_start;
  string test_name;

  // Step monitor state and expected results in move order
  int   moves_done = 0;
  int   cur_steps = 0;
  logic busy_prev = 1'b0;
  int   exp_steps[$];
  logic exp_dir[$];
  int   seed_val;

  stepper_spi_top #(
    .MOVE_DEPTH_BITS (MOVE_DEPTH_BITS)
  ) dut0 (
    .CLK           (CLK),
    .resetn        (resetn),
    .sck           (sck),
    .cs            (cs),
    .copi          (copi),
    .cipo          (cipo),
    .encoder_count (encoder_count),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .busy          (busy),
    .buffer_ready  (buffer_ready),
    .motor_cfg     (motor_cfg)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Reference step count from the step rule
  function automatic int expected_steps(input logic [63:0] duration,
                                        input logic signed [63:0] increment,
                                        input logic signed [63:0] incinc);
    logic signed [63:0] pos;
    logic signed [63:0] inc;
    logic signed [63:0] nxt;
    logic [63:0]        t;
    int                 count;
    pos   = '0;
    inc   = increment;
    count = 0;
    for (t = 0; t < duration; t++) begin
      nxt = pos + inc;
      if (nxt[32] != pos[32]) count++;
      pos = nxt;
      inc = inc + incinc;
    end
    return count;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // Advance n rising edges plus the drive offset
  task automatic wait_clk(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    err_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == err_at_start) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed", test_name);
      tests_failed++;
    end
  endtask

  // One mode 0 frame with SCK half period of 4 CLK
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    cs = 1'b0;
    wait_clk(4);
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      wait_clk(4);
      rx[i] = cipo;
      sck = 1'b1;
      wait_clk(4);
      sck = 1'b0;
    end
    wait_clk(4);
    cs   = 1'b1;
    copi = 1'b0;
    wait_clk(4);
  endtask

  task automatic send_move(input logic mdir, input logic [63:0] dur,
                           input logic [63:0] inc, input logic [63:0] incinc);
    logic [63:0] snap;
    logic [63:0] rx;
    exp_steps.push_back(expected_steps(dur, inc, incinc));
    exp_dir.push_back(mdir);
    snap          = {$urandom, $urandom};
    encoder_count = snap;
    spi_xfer({8'd1, 55'd0, mdir}, rx);
    // Encoder keeps moving after the header
    encoder_count = ~snap;
    spi_xfer(dur, rx);
    spi_xfer(inc, rx);
    spi_xfer(incinc, rx);
    check_val(rx, snap, "encoder snapshot reply");
  endtask

  task automatic wait_moves_done(input int target, input int limit);
    int n;
    n = 0;
    while (moves_done < target) begin
      if (n >= limit) abort_run("timeout waiting for moves to complete");
      wait_clk(1);
      n++;
    end
  endtask

  task automatic wait_ready_low(input int limit);
    int n;
    n = 0;
    while (buffer_ready !== 1'b0) begin
      if (n >= limit) abort_run("timeout waiting for buffer_ready to fall");
      wait_clk(1);
      n++;
    end
  endtask

  // Counts steps per move and compares at the end of each move
  always @(posedge CLK) begin
    if (resetn) begin
      cur_steps = 0;
      busy_prev = 1'b0;
    end else begin
      if (step === 1'b1) cur_steps++;
      if (busy_prev && busy === 1'b0) begin
        if (exp_steps.size() == 0) begin
          $display("unexpected move completion at time %0t", $time);
          errors++;
        end else begin
          check_val(cur_steps, exp_steps.pop_front(), "step count");
          check_val(dir, exp_dir.pop_front(), "direction");
        end
        cur_steps = 0;
        moves_done++;
      end
      busy_prev = (busy === 1'b1);
    end
  end

  initial begin
    logic [63:0] rx;
    int          k;
    resetn        = 1'b1;
    sck           = 1'b0;
    cs            = 1'b1;
    copi          = 1'b0;
    encoder_count = '0;
    seed_val      = $urandom(28226);
    wait_clk(4);
    resetn = 1'b0;
    wait_clk(2);

    begin_test("reset values");
    check_val(step, 1'b0, "step after reset");
    check_val(busy, 1'b0, "busy after reset");
    check_val(enable, 1'b0, "enable after reset");
    check_val(buffer_ready, 1'b1, "buffer_ready after reset");
    check_val(cipo, 1'b0, "cipo after reset");
    check_val(motor_cfg.microsteps, 3'd2, "microsteps after reset");
    check_val(motor_cfg.current, 8'd140, "current after reset");
    end_test();

    begin_test("api version");
    spi_xfer({8'd254, 56'd0}, rx);
    // Reply shows up during the tail word
    spi_xfer(64'd0, rx);
    check_val(rx, {40'd0, 8'd0, 8'd1, 8'd2}, "version reply");
    end_test();

    begin_test("motor settings");
    spi_xfer({8'd10, 55'd0, 1'b1}, rx);
    check_val(enable, 1'b1, "enable set");
    spi_xfer({8'd30, 40'd0, 8'd77, 5'd0, 3'd5}, rx);
    check_val(motor_cfg.current, 8'd77, "current set");
    check_val(motor_cfg.microsteps, 3'd5, "microsteps set");
    check_val(motor_cfg.enable, 1'b1, "enable kept");
    end_test();

    begin_test("single move");
    spi_xfer({8'd20, 48'd0, 8'd4}, rx);
    send_move(1'b1, 64'd60, 64'($urandom), 64'($urandom % 4096) - 64'd2048);
    wait_moves_done(1, 5000);
    check_val(busy, 1'b0, "busy after move");
    end_test();

    begin_test("queue fill");
    spi_xfer({8'd10, 56'd0}, rx);
    check_val(enable, 1'b0, "enable cleared");
    // First move outlasts the transfer of the others
    send_move(1'b0, 64'd4000, 64'($urandom), 64'($urandom % 4096) - 64'd2048);
    for (k = 0; k < DEPTH; k++) begin
      // Room left until the last queued move
      check_val(buffer_ready, 1'b1, "buffer_ready before full");
      send_move(k[0], 64'd50, 64'($urandom), 64'($urandom % 4096) - 64'd2048);
    end
    wait_ready_low(20);
    check_val(busy, 1'b1, "first move still running");
    wait_moves_done(DEPTH + 2, 40000);
    check_val(buffer_ready, 1'b1, "buffer_ready after drain");
    check_val(busy, 1'b0, "busy after drain");
    end_test();

    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stepper_spi_top.sv ====
`default_nettype none

module stepper_spi_top #(
  parameter int MOVE_DEPTH_BITS = 2
) (
  input  wire logic               CLK,
  input  wire logic               resetn,
  input  wire logic               sck,
  input  wire logic               cs,
  input  wire logic               copi,
  output logic                    cipo,
  input  wire logic [63:0]        encoder_count,
  output logic                    step,
  output logic                    dir,
  output logic                    enable,
  output logic                    busy,
  output logic                    buffer_ready,
  output stepper_pkg::motor_cfg_t motor_cfg
);

  // SPI word link
  logic                   word_valid;
  stepper_pkg::spi_word_t word_data;
  stepper_pkg::spi_word_t reply_data;

  // Decoder to queue
  logic               move_push;
  stepper_pkg::move_t push_move;
  logic [7:0]         clk_divisor;

  // Queue to timer
  logic               move_valid;
  logic               move_take;
  stepper_pkg::move_t head_move;

  spi_word spi_word0 (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs         (cs),
    .copi       (copi),
    .cipo       (cipo),
    .reply_data (reply_data),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  spi_cmd_decoder dec0 (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .encoder_count (encoder_count),
    .reply_data    (reply_data),
    .move_push     (move_push),
    .push_move     (push_move),
    .motor_cfg     (motor_cfg),
    .clk_divisor   (clk_divisor)
  );

  move_queue #(
    .MOVE_DEPTH_BITS (MOVE_DEPTH_BITS)
  ) queue0 (
    .CLK          (CLK),
    .resetn       (resetn),
    .move_push    (move_push),
    .push_move    (push_move),
    .move_take    (move_take),
    .move_valid   (move_valid),
    .head_move    (head_move),
    .buffer_ready (buffer_ready)
  );

  dda_timer dda0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .clk_divisor (clk_divisor),
    .move_valid  (move_valid),
    .head_move   (head_move),
    .move_take   (move_take),
    .step        (step),
    .dir         (dir),
    .busy        (busy)
  );

  // Driver enable straight from the config
  assign enable = motor_cfg.enable;

endmodule

`default_nettype wire

// ==== dda_timer.sv ====
`default_nettype none

module dda_timer (
  input  wire logic               CLK,
  input  wire logic               resetn,
  input  wire logic [7:0]         clk_divisor,
  input  wire logic               move_valid,
  input  wire stepper_pkg::move_t head_move,
  output logic                    move_take,
  output logic                    step,
  output logic                    dir,
  output logic                    busy
);

  // Tick divider and ticks done in this move
  logic [7:0]  div_cnt;
  logic [63:0] tick_cnt;
  logic        tick;
  logic        move_done;

  // Active move state
  logic [63:0]        duration;
  logic signed [63:0] increment;
  logic signed [63:0] incinc;
  logic signed [63:0] position;
  logic signed [63:0] next_pos;

  // Divisor of 0 or 1 ticks every CLK
  assign tick      = busy && ({1'b0, div_cnt} + 9'd1 >= {1'b0, clk_divisor});
  assign move_done = (tick_cnt == duration);
  assign next_pos  = position + increment;

  // Take the head move whenever idle
  assign move_take = move_valid && !busy;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      busy     <= 1'b0;
      step     <= 1'b0;
      dir      <= 1'b0;
      div_cnt  <= '0;
      tick_cnt <= '0;
    end else begin
      step <= 1'b0;
      if (move_take) begin
        busy     <= 1'b1;
        dir      <= head_move.dir;
        div_cnt  <= '0;
        tick_cnt <= '0;
      end else if (busy) begin
        if (move_done) begin
          busy <= 1'b0;
        end else if (tick) begin
          div_cnt  <= '0;
          tick_cnt <= tick_cnt + 64'd1;
          // Step whenever bit 32 of position flips
          step     <= next_pos[32] ^ position[32];
        end else begin
          div_cnt <= div_cnt + 8'd1;
        end
      end
    end
  end

  // Accumulator, loaded at move start
  always_ff @(posedge CLK) begin
    if (move_take) begin
      duration  <= head_move.duration;
      increment <= head_move.increment;
      incinc    <= head_move.incinc;
      position  <= '0;
    end else if (busy && !move_done && tick) begin
      position  <= next_pos;
      increment <= increment + incinc;
    end
  end

  // No step outside an active move
  a_step_busy: assert property (@(posedge CLK) disable iff (resetn)
    step |-> busy);

endmodule

`default_nettype wire

// ==== move_queue.sv ====
`default_nettype none

module move_queue #(
  parameter int MOVE_DEPTH_BITS = 2
) (
  input  wire logic               CLK,
  input  wire logic               resetn,
  input  wire logic               move_push,
  input  wire stepper_pkg::move_t push_move,
  input  wire logic               move_take,
  output logic                    move_valid,
  output stepper_pkg::move_t      head_move,
  output logic                    buffer_ready
);

  localparam int DEPTH = 1 << MOVE_DEPTH_BITS;

  stepper_pkg::move_t mem [DEPTH];

  // Extra top bit tells full from empty
  logic [MOVE_DEPTH_BITS:0] wr_idx;
  logic [MOVE_DEPTH_BITS:0] rd_idx;

  logic empty;
  logic full;

  assign empty = (wr_idx == rd_idx);
  assign full  = (wr_idx[MOVE_DEPTH_BITS] != rd_idx[MOVE_DEPTH_BITS]) &&
                 (wr_idx[MOVE_DEPTH_BITS-1:0] == rd_idx[MOVE_DEPTH_BITS-1:0]);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx <= '0;
      rd_idx <= '0;
    end else begin
      // Push into a full queue is lost
      if (move_push && !full) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (move_take && !empty) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_push && !full) begin
      mem[wr_idx[MOVE_DEPTH_BITS-1:0]] <= push_move;
    end
  end

  assign head_move    = mem[rd_idx[MOVE_DEPTH_BITS-1:0]];
  assign move_valid   = !empty;
  assign buffer_ready = !full;

  // Timer takes only a move that is there
  a_take_valid: assert property (@(posedge CLK) disable iff (resetn)
    move_take |-> move_valid);

endmodule

`default_nettype wire

// ==== spi_cmd_decoder.sv ====
`default_nettype none

module spi_cmd_decoder (
  input  wire logic                   CLK,
  input  wire logic                   resetn,
  input  wire logic                   word_valid,
  input  wire stepper_pkg::spi_word_t word_data,
  input  wire logic [63:0]            encoder_count,
  output stepper_pkg::spi_word_t      reply_data,
  output logic                        move_push,
  output stepper_pkg::move_t          push_move,
  output stepper_pkg::motor_cfg_t     motor_cfg,
  output logic [7:0]                  clk_divisor
);

  stepper_pkg::dec_state_e state;
  stepper_pkg::cmd_e       header;

  // Encoder value taken at the move header
  logic [63:0] encoder_store;

  // Header byte, only meaningful in ST_HEADER
  assign header = stepper_pkg::cmd_e'(word_data[63:56]);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state                <= stepper_pkg::ST_HEADER;
      move_push            <= 1'b0;
      reply_data           <= '0;
      clk_divisor          <= stepper_pkg::CLK_DIVISOR_RESET;
      motor_cfg.enable     <= 1'b0;
      motor_cfg.microsteps <= stepper_pkg::MICROSTEPS_RESET;
      motor_cfg.current    <= stepper_pkg::CURRENT_RESET;
    end else begin
      move_push <= 1'b0;
      if (word_valid) begin
        // Reply is zero unless a state below sets it
        reply_data <= '0;
        case (state)
          stepper_pkg::ST_HEADER: begin
            case (header)
              stepper_pkg::CMD_COORDINATED_STEP: begin
                state <= stepper_pkg::ST_DURATION;
              end
              stepper_pkg::CMD_MOTOR_ENABLE: begin
                motor_cfg.enable <= word_data[0];
              end
              stepper_pkg::CMD_CLK_DIVISOR: begin
                clk_divisor <= word_data[7:0];
              end
              stepper_pkg::CMD_MOTORCONFIG: begin
                motor_cfg.current    <= word_data[15:8];
                motor_cfg.microsteps <= word_data[2:0];
              end
              stepper_pkg::CMD_API_VERSION: begin
                // Patch low, then minor, then major
                reply_data <= {40'd0, stepper_pkg::VERSION_MAJOR,
                               stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH};
                state      <= stepper_pkg::ST_VERSION_TAIL;
              end
              default: begin
                state <= stepper_pkg::ST_HEADER;
              end
            endcase
          end
          stepper_pkg::ST_DURATION: begin
            state <= stepper_pkg::ST_INCREMENT;
          end
          stepper_pkg::ST_INCREMENT: begin
            // Encoder snapshot goes out with the last move word
            reply_data <= encoder_store;
            state      <= stepper_pkg::ST_INCINC;
          end
          stepper_pkg::ST_INCINC: begin
            move_push <= 1'b1;
            state     <= stepper_pkg::ST_HEADER;
          end
          stepper_pkg::ST_VERSION_TAIL: begin
            // Tail word content is ignored
            state <= stepper_pkg::ST_HEADER;
          end
          default: begin
            state <= stepper_pkg::ST_HEADER;
          end
        endcase
      end
    end
  end

  // Move fields and encoder snapshot
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        stepper_pkg::ST_HEADER: begin
          if (header == stepper_pkg::CMD_COORDINATED_STEP) begin
            push_move.dir <= word_data[0];
            encoder_store <= encoder_count;
          end
        end
        stepper_pkg::ST_DURATION:  push_move.duration  <= word_data;
        stepper_pkg::ST_INCREMENT: push_move.increment <= word_data;
        stepper_pkg::ST_INCINC:    push_move.incinc    <= word_data;
        default: begin
          encoder_store <= encoder_store;
        end
      endcase
    end
  end

  // Push only ever follows the last move word
  a_push_after_incinc: assert property (@(posedge CLK) disable iff (resetn)
    move_push |-> $past(state) == stepper_pkg::ST_INCINC);

endmodule

`default_nettype wire

// ==== spi_word.sv ====
`default_nettype none

module spi_word (
  input  wire logic                  CLK,
  input  wire logic                  resetn,
  input  wire logic                  sck,
  input  wire logic                  cs,
  input  wire logic                  copi,
  output logic                       cipo,
  input  wire stepper_pkg::spi_word_t reply_data,
  output logic                       word_valid,
  output stepper_pkg::spi_word_t     word_data
);

  // Two sync stages plus one history stage for edge detect
  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [1:0] copi_r;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_low;

  // Bit position within the current word
  logic [5:0] bit_cnt;

  stepper_pkg::spi_word_t rx_shift;
  stepper_pkg::spi_word_t tx_shift;

  always_ff @(posedge CLK) begin
    sck_r  <= {sck_r[1:0], sck};
    cs_r   <= {cs_r[1:0], cs};
    copi_r <= {copi_r[0], copi};
  end

  assign sck_rise = sck_r[1] & ~sck_r[2];
  assign sck_fall = ~sck_r[1] & sck_r[2];
  assign cs_fall  = ~cs_r[1] & cs_r[2];
  assign cs_low   = ~cs_r[1];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
      tx_shift   <= '0;
    end else begin
      // Last bit of the word arrives on count 63
      word_valid <= cs_low && sck_rise && (bit_cnt == 6'd63);
      if (!cs_low) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 6'd1;
      end
      // Reply loaded at CS fall and sent MSB first
      if (cs_fall) begin
        tx_shift <= reply_data;
      end else if (cs_low && sck_fall) begin
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  // Receive shift with MSB first
  always_ff @(posedge CLK) begin
    if (cs_low && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_r[1]};
    end
  end

  assign word_data = rx_shift;
  assign cipo      = tx_shift[63];

  // A word completes only inside a CS low frame
  a_word_in_frame: assert property (@(posedge CLK) disable iff (resetn)
    word_valid |-> !cs_r[1]);

endmodule

`default_nettype wire

// ==== stepper_pkg.sv ====
`default_nettype none

package stepper_pkg;

  // One SPI word, header in the top byte
  typedef logic [63:0] spi_word_t;

  // Host command headers, bits 63 to 56
  typedef enum logic [7:0] {
    CMD_NONE             = 8'd0,
    CMD_COORDINATED_STEP = 8'd1,
    CMD_MOTOR_ENABLE     = 8'd10,
    CMD_CLK_DIVISOR      = 8'd20,
    CMD_MOTORCONFIG      = 8'd30,
    CMD_API_VERSION      = 8'd254
  } cmd_e;

  // Decoder message states
  typedef enum logic [2:0] {
    ST_HEADER,
    ST_DURATION,
    ST_INCREMENT,
    ST_INCINC,
    ST_VERSION_TAIL
  } dec_state_e;

  // One buffered move, 193 bits
  typedef struct packed {
    logic               dir;
    logic [63:0]        duration;
    logic signed [63:0] increment;
    logic signed [63:0] incinc;
  } move_t;

  // Motor driver settings
  typedef struct packed {
    logic       enable;
    logic [2:0] microsteps;
    logic [7:0] current;
  } motor_cfg_t;

  // Reported by the API version command
  parameter logic [7:0] VERSION_MAJOR = 8'd0;
  parameter logic [7:0] VERSION_MINOR = 8'd1;
  parameter logic [7:0] VERSION_PATCH = 8'd2;

  // Power-up settings
  parameter logic [7:0] CLK_DIVISOR_RESET = 8'd40;
  parameter logic [2:0] MICROSTEPS_RESET  = 3'd2;
  parameter logic [7:0] CURRENT_RESET     = 8'd140;

endpackage

`default_nettype wire
